// ==== verilog/core_pkg.sv ====
package core_pkg;

    // ************************************************************************
    // datapath sizes
    // ************************************************************************

    // operand and partial sum widths
    localparam int BW      = 4;
    localparam int PSUM_BW = 16;

    // array shape, rows are input channels
    localparam int ROW = 8;
    localparam int COL = 8;

    // sram geometry
    localparam int ADDR_W = 11;
    localparam int DEPTH  = 2048;

    // buffer depths
    localparam int OFIFO_DEPTH = 8;
    localparam int L0_DEPTH    = 8;

    // l0 pop to ofifo push
    localparam int ARRAY_LAT = ROW + COL;

    // ************************************************************************
    // instruction word layout
    // ************************************************************************

    localparam int INST_W = 64;

    localparam int F_LOAD        = 0;
    localparam int F_EXECUTE     = 1;
    localparam int F_L0_WR       = 2;
    localparam int F_L0_RD       = 3;
    localparam int F_OFIFO_RD    = 6;
    localparam int F_A_XMEM_LSB  = 7;
    localparam int F_WEN_XMEM    = 18;
    localparam int F_CEN_XMEM    = 19;
    localparam int F_A_PMEM_LSB  = 20;
    localparam int F_WEN_PMEM    = 31;
    localparam int F_CEN_PMEM    = 32;
    localparam int F_ACC         = 33;
    localparam int F_PASSTHROUGH = 34;
    localparam int F_REN_PMEM    = 35;
    localparam int F_ACT_LSB     = 36;

    // bits that arrive active low
    localparam logic [INST_W-1:0] INST_LOW_MASK = (64'd1 << F_WEN_XMEM)
                                                | (64'd1 << F_CEN_XMEM)
                                                | (64'd1 << F_WEN_PMEM)
                                                | (64'd1 << F_CEN_PMEM);

    // activation function codes
    localparam logic [1:0] ACT_NONE = 2'd0;
    localparam logic [1:0] ACT_RELU = 2'd1;

    // row payloads
    typedef logic signed [BW-1:0]      act_t;
    typedef act_t [ROW-1:0]            act_row_t;
    typedef logic signed [PSUM_BW-1:0] psum_t;
    typedef psum_t [COL-1:0]           psum_row_t;

endpackage

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::INST_W-1:0] inst_i,
    output logic                        load_o,
    output logic                        execute_o,
    output logic                        l0_wr_o,
    output logic                        l0_rd_o,
    output logic                        ofifo_rd_o,
    output logic                        xmem_en_o,
    output logic                        xmem_we_o,
    output logic [core_pkg::ADDR_W-1:0] xmem_addr_o,
    output logic                        pmem_en_o,
    output logic                        pmem_we_o,
    output logic [core_pkg::ADDR_W-1:0] pmem_addr_o,
    output logic                        acc_o,
    output logic                        passthrough_o,
    output logic [1:0]                  act_o
);

    // word held with every field active high, zero is idle
    logic [core_pkg::INST_W-1:0] inst_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_q <= '0;
        end else begin
            // flip the active-low enables on the way in
            inst_q <= inst_i ^ core_pkg::INST_LOW_MASK;
        end
    end

    // array and buffer strobes
    assign load_o     = inst_q[core_pkg::F_LOAD];
    assign execute_o  = inst_q[core_pkg::F_EXECUTE];
    assign l0_wr_o    = inst_q[core_pkg::F_L0_WR];
    assign l0_rd_o    = inst_q[core_pkg::F_L0_RD];
    assign ofifo_rd_o = inst_q[core_pkg::F_OFIFO_RD];

    // xmem port, write only when selected
    assign xmem_en_o   = inst_q[core_pkg::F_CEN_XMEM];
    assign xmem_we_o   = inst_q[core_pkg::F_CEN_XMEM] & inst_q[core_pkg::F_WEN_XMEM];
    assign xmem_addr_o = inst_q[core_pkg::F_A_XMEM_LSB +: core_pkg::ADDR_W];

    // pmem port, a read also needs ren
    assign pmem_en_o   = inst_q[core_pkg::F_CEN_PMEM]
                       & (inst_q[core_pkg::F_WEN_PMEM] | inst_q[core_pkg::F_REN_PMEM]);
    assign pmem_we_o   = inst_q[core_pkg::F_CEN_PMEM] & inst_q[core_pkg::F_WEN_PMEM];
    assign pmem_addr_o = inst_q[core_pkg::F_A_PMEM_LSB +: core_pkg::ADDR_W];

    // sfp controls
    assign acc_o         = inst_q[core_pkg::F_ACC];
    assign passthrough_o = inst_q[core_pkg::F_PASSTHROUGH];
    assign act_o         = inst_q[core_pkg::F_ACT_LSB +: 2];

endmodule

// ==== verilog/sram_sp.sv ====
`timescale 1ns/1ps

module sram_sp #(
    parameter type payload_t = logic [31:0]
) (
    input  logic                        clk,
    input  logic                        en_i,
    input  logic                        we_i,
    input  logic [core_pkg::ADDR_W-1:0] addr_i,
    input  payload_t                    d_i,
    output payload_t                    q_o
);

    // storage array
    payload_t mem [core_pkg::DEPTH];

    // single port, write wins over read
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= d_i;
            end else begin
                // read data lands one cycle later
                q_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== verilog/row_fifo.sv ====
`timescale 1ns/1ps

module row_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH_P   = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_i,
    input  logic     rd_i,
    input  payload_t d_i,
    output payload_t q_o,
    output logic     full_o,
    output logic     valid_o
);

    // circular storage
    payload_t mem [DEPTH_P];

    // pointers wrap on their own at a power of two
    logic [$clog2(DEPTH_P)-1:0] wr_ptr;
    logic [$clog2(DEPTH_P)-1:0] rd_ptr;
    logic [$clog2(DEPTH_P):0]   count;
    logic                       push;
    logic                       pop;

    // push on full dropped, pop on empty ignored
    assign push = wr_i & ~full_o;
    assign pop  = rd_i & valid_o;

    assign full_o  = (count == DEPTH_P);
    assign valid_o = (count != 0);

    // head shows without latency
    assign q_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // data store
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= d_i;
        end
    end

endmodule

// ==== verilog/mac_tile.sv ====
`timescale 1ns/1ps

module mac_tile (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::act_t  a_i,
    input  core_pkg::psum_t p_i,
    input  logic            load_i,
    input  logic            execute_i,
    input  logic            valid_i,
    output core_pkg::act_t  a_o,
    output core_pkg::psum_t p_o,
    output logic            valid_o
);

    // stationary weight
    core_pkg::act_t  weight_q;
    // product sign-extended to psum width
    core_pkg::psum_t prod;

    assign prod = weight_q * a_i;

    // token follows the activation east
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            // forward east in both modes
            a_o <= a_i;
        end
        if (valid_i && load_i) begin
            weight_q <= a_i;
        end
        if (valid_i && execute_i) begin
            // accumulate and pass south
            p_o <= p_i + prod;
        end
    end

endmodule

// ==== verilog/mac_array.sv ====
`timescale 1ns/1ps

module mac_array (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::act_row_t  in_i,
    input  logic                in_valid_i,
    input  logic                load_i,
    input  logic                execute_i,
    output core_pkg::psum_row_t out_o,
    output logic                out_valid_o
);

    // horizontal activation and token links
    core_pkg::act_t  a_h [core_pkg::ROW][core_pkg::COL+1];
    logic            v_h [core_pkg::ROW][core_pkg::COL+1];
    // vertical psum links, row 0 is the north edge
    core_pkg::psum_t p_v [core_pkg::ROW+1][core_pkg::COL];

    // load follows the row skew only, column c sees it end c cycles early
    logic [core_pkg::ROW-2:0]       ld_pipe;
    logic [core_pkg::ROW-1:0]       ld_tap;
    // execute follows the whole wavefront, tap k is k cycles old
    logic [core_pkg::ARRAY_LAT-2:0] ex_pipe;
    logic [core_pkg::ARRAY_LAT-1:0] ex_tap;

    // bottom edge after deskew
    core_pkg::psum_row_t south_d;

    assign ld_tap = {ld_pipe, load_i};
    assign ex_tap = {ex_pipe, execute_i};

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_pipe     <= '0;
            ex_pipe     <= '0;
            out_valid_o <= 1'b0;
        end else begin
            ld_pipe     <= {ld_pipe[core_pkg::ROW-3:0], load_i};
            ex_pipe     <= {ex_pipe[core_pkg::ARRAY_LAT-3:0], execute_i};
            // corner token with its execute bit marks a full row
            out_valid_o <= v_h[core_pkg::ROW-1][core_pkg::COL]
                         & ex_tap[core_pkg::ARRAY_LAT-1];
        end
    end

    // ************************************************************************
    // west skew and tile grid
    // ************************************************************************

    for (genvar r = 0; r < core_pkg::ROW; r++) begin : g_row
        if (r == 0) begin : g_direct
            assign a_h[r][0] = in_i[r];
            assign v_h[r][0] = in_valid_i;
        end else begin : g_skew
            core_pkg::act_t a_sr [r];
            logic [r-1:0]   v_sr;

            // row r delayed by r cycles
            always_ff @(posedge clk) begin
                a_sr[0] <= in_i[r];
                for (int k = 1; k < r; k++) begin
                    a_sr[k] <= a_sr[k-1];
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= in_valid_i;
                    for (int k = 1; k < r; k++) begin
                        v_sr[k] <= v_sr[k-1];
                    end
                end
            end

            assign a_h[r][0] = a_sr[r-1];
            assign v_h[r][0] = v_sr[r-1];
        end

        for (genvar c = 0; c < core_pkg::COL; c++) begin : g_col
            // column c keeps the last load word it sees, word COL-1-c
            mac_tile u_tile (
                .clk       (clk),
                .reset     (reset),
                .a_i       (a_h[r][c]),
                .p_i       (p_v[r][c]),
                .load_i    (ld_tap[r]),
                .execute_i (ex_tap[r+c]),
                .valid_i   (v_h[r][c]),
                .a_o       (a_h[r][c+1]),
                .p_o       (p_v[r+1][c]),
                .valid_o   (v_h[r][c+1])
            );
        end
    end

    // ************************************************************************
    // north zero and south deskew
    // ************************************************************************

    for (genvar c = 0; c < core_pkg::COL; c++) begin : g_edge
        assign p_v[0][c] = '0;

        if (c == core_pkg::COL-1) begin : g_direct
            assign south_d[c] = p_v[core_pkg::ROW][c];
        end else begin : g_deskew
            core_pkg::psum_t d_sr [core_pkg::COL-1-c];

            // earlier columns wait for the last one
            always_ff @(posedge clk) begin
                d_sr[0] <= p_v[core_pkg::ROW][c];
                for (int k = 1; k < core_pkg::COL-1-c; k++) begin
                    d_sr[k] <= d_sr[k-1];
                end
            end

            assign south_d[c] = d_sr[core_pkg::COL-2-c];
        end
    end

    // output row register
    always_ff @(posedge clk) begin
        out_o <= south_d;
    end

endmodule

// ==== verilog/sfp.sv ====
`timescale 1ns/1ps

module sfp (
    input  core_pkg::psum_t psum_i,
    input  core_pkg::psum_t head_i,
    input  logic            acc_i,
    input  logic            passthrough_i,
    input  logic [1:0]      act_i,
    output core_pkg::psum_t out_o
);

    core_pkg::psum_t base;
    core_pkg::psum_t activated;

    // add stored psum when accumulating
    assign base = acc_i ? (head_i + psum_i) : head_i;

    // relu clamps negatives to zero
    always_comb begin
        activated = base;
        if (act_i == core_pkg::ACT_RELU && base < 0) begin
            activated = '0;
        end
    end

    // passthrough skips both stages
    assign out_o = passthrough_i ? head_i : activated;

endmodule

// ==== verilog/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [core_pkg::INST_W-1:0] inst_i,
    input  core_pkg::act_row_t          d_xmem_i,
    output logic                        ofifo_valid_o,
    output core_pkg::psum_row_t         sfp_out_o
);

    // decoded strobes
    logic                        load;
    logic                        execute;
    logic                        l0_wr;
    logic                        l0_rd;
    logic                        ofifo_rd;
    logic                        xmem_en;
    logic                        xmem_we;
    logic [core_pkg::ADDR_W-1:0] xmem_addr;
    logic                        pmem_en;
    logic                        pmem_we;
    logic [core_pkg::ADDR_W-1:0] pmem_addr;
    logic                        acc;
    logic                        passthrough;
    logic [1:0]                  act;

    // datapath links
    core_pkg::act_row_t  xmem_q;
    core_pkg::act_row_t  l0_head;
    logic                l0_valid;
    logic                l0_pop;
    core_pkg::psum_row_t array_out;
    logic                array_valid;
    core_pkg::psum_row_t ofifo_head;
    core_pkg::psum_row_t pmem_q;

    // only a real pop reaches the array
    assign l0_pop = l0_rd & l0_valid;

    inst_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .inst_i        (inst_i),
        .load_o        (load),
        .execute_o     (execute),
        .l0_wr_o       (l0_wr),
        .l0_rd_o       (l0_rd),
        .ofifo_rd_o    (ofifo_rd),
        .xmem_en_o     (xmem_en),
        .xmem_we_o     (xmem_we),
        .xmem_addr_o   (xmem_addr),
        .pmem_en_o     (pmem_en),
        .pmem_we_o     (pmem_we),
        .pmem_addr_o   (pmem_addr),
        .acc_o         (acc),
        .passthrough_o (passthrough),
        .act_o         (act)
    );

    // activation and weight memory
    sram_sp #(.payload_t(core_pkg::act_row_t)) u_xmem (
        .clk    (clk),
        .en_i   (xmem_en),
        .we_i   (xmem_we),
        .addr_i (xmem_addr),
        .d_i    (d_xmem_i),
        .q_o    (xmem_q)
    );

    // west row buffer
    row_fifo #(.payload_t(core_pkg::act_row_t), .DEPTH_P(core_pkg::L0_DEPTH)) u_l0 (
        .clk     (clk),
        .reset   (reset),
        .wr_i    (l0_wr),
        .rd_i    (l0_rd),
        .d_i     (xmem_q),
        .q_o     (l0_head),
        .full_o  (),
        .valid_o (l0_valid)
    );

    mac_array u_array (
        .clk         (clk),
        .reset       (reset),
        .in_i        (l0_head),
        .in_valid_i  (l0_pop),
        .load_i      (load),
        .execute_i   (execute),
        .out_o       (array_out),
        .out_valid_o (array_valid)
    );

    // output row buffer
    row_fifo #(.payload_t(core_pkg::psum_row_t), .DEPTH_P(core_pkg::OFIFO_DEPTH)) u_ofifo (
        .clk     (clk),
        .reset   (reset),
        .wr_i    (array_valid),
        .rd_i    (ofifo_rd),
        .d_i     (array_out),
        .q_o     (ofifo_head),
        .full_o  (),
        .valid_o (ofifo_valid_o)
    );

    // psum memory, written back from the sfp result
    sram_sp #(.payload_t(core_pkg::psum_row_t)) u_pmem (
        .clk    (clk),
        .en_i   (pmem_en),
        .we_i   (pmem_we),
        .addr_i (pmem_addr),
        .d_i    (sfp_out_o),
        .q_o    (pmem_q)
    );

    // one lane per column
    for (genvar c = 0; c < core_pkg::COL; c++) begin : g_sfp
        sfp u_sfp (
            .psum_i        (pmem_q[c]),
            .head_i        (ofifo_head[c]),
            .acc_i         (acc),
            .passthrough_i (passthrough),
            .act_i         (act),
            .out_o         (sfp_out_o[c])
        );
    end

endmodule

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    // ************************************************************************
    // run length
    // ************************************************************************

    // stage a full l0, issue it, let it fly and drain it
    localparam int PHASE_CYCLES = 4 * (core_pkg::L0_DEPTH + 1) + core_pkg::ARRAY_LAT;
    // six phases plus the idle stretches
    localparam int RUN_CYCLES   = 6 * PHASE_CYCLES + 4 * core_pkg::ARRAY_LAT;
    localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * 4;
    // first row due ARRAY_LAT after the last pop
    localparam int VALID_WAIT   = 2 * core_pkg::ARRAY_LAT + core_pkg::L0_DEPTH;

    logic                        clk = 1'b0;
    logic                        reset;
    logic [core_pkg::INST_W-1:0] inst_i;
    core_pkg::act_row_t          d_xmem_i;
    logic                        ofifo_valid_o;
    core_pkg::psum_row_t         sfp_out_o;

    // reference model state
    int                  wgt [core_pkg::ROW][core_pkg::COL];
    core_pkg::act_row_t  load_words [core_pkg::COL];
    core_pkg::act_row_t  act_q [$];
    core_pkg::psum_row_t exp_q [$];
    core_pkg::psum_row_t first_pass [core_pkg::L0_DEPTH];
    // xmem write data trails its instruction by one cycle
    core_pkg::act_row_t  d_next;

    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;

    core DUT (
        .clk           (clk),
        .reset         (reset),
        .inst_i        (inst_i),
        .d_xmem_i      (d_xmem_i),
        .ofifo_valid_o (ofifo_valid_o),
        .sfp_out_o     (sfp_out_o)
    );

    always #2 clk = ~clk;

    // ************************************************************************
    // instruction words
    // ************************************************************************

    // all strobes off, active-low enables high
    function automatic logic [core_pkg::INST_W-1:0] idle_word();
        logic [core_pkg::INST_W-1:0] w;
        w = '0;
        w[core_pkg::F_WEN_XMEM] = 1'b1;
        w[core_pkg::F_CEN_XMEM] = 1'b1;
        w[core_pkg::F_WEN_PMEM] = 1'b1;
        w[core_pkg::F_CEN_PMEM] = 1'b1;
        return w;
    endfunction

    function automatic logic [core_pkg::INST_W-1:0] xmem_access(
        input logic [core_pkg::INST_W-1:0] w, input int addr, input bit write);
        w[core_pkg::F_CEN_XMEM] = 1'b0;
        w[core_pkg::F_WEN_XMEM] = !write;
        w[core_pkg::F_A_XMEM_LSB +: core_pkg::ADDR_W] = addr[core_pkg::ADDR_W-1:0];
        return w;
    endfunction

    // reads also need ren
    function automatic logic [core_pkg::INST_W-1:0] pmem_access(
        input logic [core_pkg::INST_W-1:0] w, input int addr, input bit write);
        w[core_pkg::F_CEN_PMEM] = 1'b0;
        w[core_pkg::F_WEN_PMEM] = !write;
        w[core_pkg::F_REN_PMEM] = !write;
        w[core_pkg::F_A_PMEM_LSB +: core_pkg::ADDR_W] = addr[core_pkg::ADDR_W-1:0];
        return w;
    endfunction

    // ofifo pop with the sfp controls
    function automatic logic [core_pkg::INST_W-1:0] read_word(
        input logic acc, input logic pass, input logic [1:0] act);
        logic [core_pkg::INST_W-1:0] w;
        w = idle_word();
        w[core_pkg::F_OFIFO_RD]    = 1'b1;
        w[core_pkg::F_ACC]         = acc;
        w[core_pkg::F_PASSTHROUGH] = pass;
        w[core_pkg::F_ACT_LSB +: 2] = act;
        return w;
    endfunction

    // ************************************************************************
    // reference model
    // ************************************************************************

    // operands in -8..7
    function automatic core_pkg::act_row_t random_row();
        core_pkg::act_row_t row;
        for (int r = 0; r < core_pkg::ROW; r++) begin
            row[r] = core_pkg::act_t'($urandom_range(15, 0));
        end
        return row;
    endfunction

    // column sums over the input channels
    function automatic core_pkg::psum_row_t model_row(input core_pkg::act_row_t a, input bit relu);
        core_pkg::psum_row_t row;
        int                  s;
        for (int c = 0; c < core_pkg::COL; c++) begin
            s = 0;
            for (int r = 0; r < core_pkg::ROW; r++) begin
                s += wgt[r][c] * int'($signed(a[r]));
            end
            if (relu && s < 0) begin
                s = 0;
            end
            row[c] = core_pkg::psum_t'(s);
        end
        return row;
    endfunction

    function automatic core_pkg::psum_row_t sum_rows(
        input core_pkg::psum_row_t a, input core_pkg::psum_row_t b);
        core_pkg::psum_row_t row;
        for (int c = 0; c < core_pkg::COL; c++) begin
            row[c] = core_pkg::psum_t'(int'($signed(a[c])) + int'($signed(b[c])));
        end
        return row;
    endfunction

    // ************************************************************************
    // drivers and checks
    // ************************************************************************

    // called on a falling edge, returns on the next one
    task automatic issue(input logic [core_pkg::INST_W-1:0] w, input core_pkg::act_row_t d);
        inst_i   = w;
        d_xmem_i = d_next;
        d_next   = d;
        @(negedge clk);
    endtask

    task automatic check_row(input core_pkg::psum_row_t expected);
        assert (sfp_out_o === expected) else begin
            $display("Mismatch at %0t: sfp_out_o expected %h got %h",
                     $time, expected, sfp_out_o);
            errors++;
        end
    endtask

    task automatic check_valid(input logic expected);
        assert (ofifo_valid_o === expected) else begin
            $display("Mismatch at %0t: ofifo_valid_o expected %b got %b",
                     $time, expected, ofifo_valid_o);
            errors++;
        end
    endtask

    // act_q into xmem from address zero, then into l0
    task automatic stage_rows();
        logic [core_pkg::INST_W-1:0] w;
        foreach (act_q[i]) begin
            issue(xmem_access(idle_word(), i, 1'b1), act_q[i]);
        end
        // push lags each read by one cycle
        for (int i = 0; i <= act_q.size(); i++) begin
            w = idle_word();
            if (i < act_q.size()) begin
                w = xmem_access(w, i, 1'b0);
            end
            if (i > 0) begin
                w[core_pkg::F_L0_WR] = 1'b1;
            end
            issue(w, '0);
        end
    endtask

    // pop l0 into the array with load or execute held
    task automatic issue_rows(input int mode);
        logic [core_pkg::INST_W-1:0] w;
        w = idle_word();
        w[core_pkg::F_L0_RD] = 1'b1;
        w[mode]              = 1'b1;
        repeat (act_q.size()) begin
            issue(w, '0);
        end
    endtask

    task automatic wait_ofifo();
        int n;
        n = 0;
        while (!ofifo_valid_o && n < VALID_WAIT) begin
            issue(idle_word(), '0);
            n++;
        end
        assert (ofifo_valid_o) else begin
            $display("ofifo_valid_o did not rise within %0d cycles of execute", VALID_WAIT);
            errors++;
        end
    endtask

    task automatic run_vectors(input int n, input bit relu);
        core_pkg::act_row_t row;
        act_q.delete();
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            row = random_row();
            act_q.push_back(row);
            exp_q.push_back(model_row(row, relu));
        end
        stage_rows();
        issue_rows(core_pkg::F_EXECUTE);
        wait_ofifo();
    endtask

    // head is on sfp_out_o the cycle before its pop
    task automatic drain(input logic [core_pkg::INST_W-1:0] w);
        while (exp_q.size() > 0) begin
            issue(w, '0);
            check_valid(1'b1);
            check_row(exp_q.pop_front());
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: %0d failed checks", $time, name, errors - test_errors);
        end
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        logic [core_pkg::INST_W-1:0] word;
        void'($urandom(26));
        reset        = 1'b1;
        inst_i       = idle_word();
        d_xmem_i     = '0;
        d_next       = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // nothing reaches the ofifo without execute
        begin_test();
        repeat (core_pkg::ARRAY_LAT) begin
            issue(idle_word(), '0);
            check_valid(1'b0);
        end
        // a distinct word per load cycle so every column differs
        act_q.delete();
        for (int i = 0; i < core_pkg::COL; i++) begin
            load_words[i] = random_row();
            act_q.push_back(load_words[i]);
        end
        stage_rows();
        issue_rows(core_pkg::F_LOAD);
        repeat (2 * core_pkg::ARRAY_LAT) begin
            issue(idle_word(), '0);
            check_valid(1'b0);
        end
        // column c keeps the word of load cycle COL-1-c
        for (int r = 0; r < core_pkg::ROW; r++) begin
            for (int c = 0; c < core_pkg::COL; c++) begin
                wgt[r][c] = int'($signed(load_words[core_pkg::COL-1-c][r]));
            end
        end
        end_test("idle after reset and weight load");

        begin_test();
        run_vectors(core_pkg::L0_DEPTH, 1'b0);
        drain(read_word(1'b0, 1'b1, core_pkg::ACT_NONE));
        end_test("passthrough column sums");

        // first pass written back to pmem unchanged
        begin_test();
        run_vectors(core_pkg::L0_DEPTH, 1'b0);
        for (int i = 0; i < core_pkg::L0_DEPTH; i++) begin
            first_pass[i] = exp_q.pop_front();
            issue(pmem_access(read_word(1'b0, 1'b0, core_pkg::ACT_NONE), i, 1'b1), '0);
            check_row(first_pass[i]);
        end
        run_vectors(core_pkg::L0_DEPTH, 1'b0);
        // pmem read runs one cycle ahead of the accumulate
        for (int k = 0; k <= core_pkg::L0_DEPTH; k++) begin
            word = (k > 0) ? read_word(1'b1, 1'b0, core_pkg::ACT_NONE) : idle_word();
            if (k < core_pkg::L0_DEPTH) begin
                word = pmem_access(word, k, 1'b0);
            end
            issue(word, '0);
            if (k > 0) begin
                check_row(sum_rows(first_pass[k-1], exp_q.pop_front()));
            end
        end
        end_test("accumulate with pmem");

        begin_test();
        run_vectors(core_pkg::L0_DEPTH, 1'b1);
        drain(read_word(1'b0, 1'b0, core_pkg::ACT_RELU));
        end_test("relu");

        // fill the ofifo before any pop
        begin_test();
        run_vectors(core_pkg::OFIFO_DEPTH, 1'b0);
        repeat (core_pkg::OFIFO_DEPTH) begin
            issue(idle_word(), '0);
            check_valid(1'b1);
        end
        drain(read_word(1'b0, 1'b1, core_pkg::ACT_NONE));
        issue(idle_word(), '0);
        check_valid(1'b0);
        end_test("ordering under back-pressure");

        $display("%0d tests passed, %0d tests failed, %0d failed checks",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
verilog/core_pkg.sv
verilog/inst_decode.sv
verilog/sram_sp.sv
verilog/row_fifo.sv
verilog/mac_tile.sv
verilog/mac_array.sv
verilog/sfp.sv
verilog/core.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - verilog/core_pkg.sv
  - verilog/inst_decode.sv
  - verilog/sram_sp.sv
  - verilog/row_fifo.sv
  - verilog/mac_tile.sv
  - verilog/mac_array.sv
  - verilog/sfp.sv
  - verilog/core.sv
  - target: simulation
    files:
      - testbench/core_tb.sv
